// ==== design/rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural registers x0..x31
`define REG_COUNT 32

// Physical register file and the tags naming it
`define PHYS_COUNT 64
`define TAG_WIDTH 6

// Tags not held by the committed mapping
`define FREE_COUNT (`PHYS_COUNT - `REG_COUNT)

// Sequence numbers wrap at 64
`define SQN_WIDTH 6

`endif

// ==== design/renamePkg.sv ====
package renamePkg;

    // Operation carried through rename unchanged
    typedef enum logic [3:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOr,
        OpXor,
        OpSll,
        OpSrl,
        OpLoad,
        OpStore,
        OpBranch
    } OpCode;

    // Functional unit class the op is headed for
    typedef enum logic [1:0] {
        FuInt,
        FuLsu,
        FuBranch
    } FuKind;

    // Alias table rollback walk
    typedef enum logic {
        RollIdle,
        RollBusy
    } RollState;

endpackage

// ==== design/freeTagList.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module freeTagList (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pop,
    input  logic                  pushA,
    input  logic [`TAG_WIDTH-1:0] tagA,
    input  logic                  pushB,
    input  logic [`TAG_WIDTH-1:0] tagB,
    output logic [`TAG_WIDTH-1:0] headTag,
    output logic                  empty
);
    localparam int PTR_W = $clog2(`FREE_COUNT);
    localparam int CNT_W = $clog2(`FREE_COUNT + 1);

    logic [`TAG_WIDTH-1:0] slots [`FREE_COUNT];
    logic [PTR_W-1:0]      rdPtr;
    logic [PTR_W-1:0]      wrPtr;
    logic [CNT_W-1:0]      count;
    logic [PTR_W-1:0]      slotB;
    logic [1:0]            pushNum;
    logic                  popOk;

    // Tag B goes in behind tag A when both ports fire
    assign slotB   = pushA ? wrPtr + PTR_W'(1) : wrPtr;
    assign pushNum = {1'b0, pushA} + {1'b0, pushB};

    assign empty   = (count == '0);
    assign popOk   = pop && !empty;
    assign headTag = slots[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= CNT_W'(`FREE_COUNT);
            // Every tag above the initial register mapping starts out free
            for (int i = 0; i < `FREE_COUNT; i++) begin
                slots[i] <= `TAG_WIDTH'(`REG_COUNT + i);
            end
        end else begin
            if (pushA) begin
                slots[wrPtr] <= tagA;
            end
            if (pushB) begin
                slots[slotB] <= tagB;
            end
            wrPtr <= wrPtr + PTR_W'(pushNum);

            if (popOk) begin
                rdPtr <= rdPtr + PTR_W'(1);
            end

            // Push and pop in one cycle both count
            count <= count + CNT_W'(pushNum) - CNT_W'(popOk);
        end
    end

endmodule

// ==== design/aliasTable.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module aliasTable (
    input  logic                          clk,
    input  logic                          rst,

    // Source lookups for the op being renamed
    input  logic [$clog2(`REG_COUNT)-1:0] rs0,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1,

    // New speculative mapping for the destination
    input  logic                          alloc,
    input  logic [$clog2(`REG_COUNT)-1:0] allocReg,
    input  logic [`TAG_WIDTH-1:0]         allocTag,

    input  logic                          wbValid,
    input  logic [$clog2(`REG_COUNT)-1:0] wbReg,
    input  logic [`TAG_WIDTH-1:0]         wbTag,

    input  logic                          comValid,
    input  logic [$clog2(`REG_COUNT)-1:0] comReg,
    input  logic [`TAG_WIDTH-1:0]         comTag,

    input  logic                          flush,

    output logic [`TAG_WIDTH-1:0]         tagA,
    output logic                          availA,
    output logic [`TAG_WIDTH-1:0]         tagB,
    output logic                          availB,

    // Tags handed back to the free list
    output logic                          retire,
    output logic [`TAG_WIDTH-1:0]         retireTag,
    output logic                          drop,
    output logic [`TAG_WIDTH-1:0]         dropTag,

    output logic                          rolling
);
    import renamePkg::*;

    localparam int IDX_W = $clog2(`REG_COUNT);

    logic [`TAG_WIDTH-1:0] specTag   [`REG_COUNT];
    logic [`TAG_WIDTH-1:0] commitTag [`REG_COUNT];
    logic                  avail     [`REG_COUNT];

    RollState              state;
    logic [IDX_W-1:0]      rollIdx;

    logic                  comHit;
    logic                  wbHit;
    logic                  allocHit;
    logic [`TAG_WIDTH-1:0] stepTag;

    // x0 is hardwired, it never gets a new tag
    assign tagA   = (rs0 == '0) ? '0 : specTag[rs0];
    assign availA = (rs0 == '0) || avail[rs0];
    assign tagB   = (rs1 == '0) ? '0 : specTag[rs1];
    assign availB = (rs1 == '0) || avail[rs1];

    assign rolling = (state == RollBusy);

    assign comHit   = comValid && (comReg != '0);
    assign allocHit = alloc && (allocReg != '0);

    // Write-backs from flushed ops are dropped, stale tags too
    assign wbHit = wbValid && (wbReg != '0) && !rolling && !flush &&
                   (specTag[wbReg] == wbTag);

    assign retire    = comHit;
    assign retireTag = commitTag[comReg];

    // A commit landing on the entry being walked wins over the stored tag
    assign stepTag = (comHit && (comReg == rollIdx)) ? comTag : commitTag[rollIdx];

    assign drop    = rolling && (specTag[rollIdx] != stepTag);
    assign dropTag = specTag[rollIdx];

    // Rollback walker, one register per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RollIdle;
            rollIdx <= '0;
        end else begin
            case (state)
                RollIdle: begin
                    if (flush) begin
                        state   <= RollBusy;
                        rollIdx <= '0;
                    end
                end
                RollBusy: begin
                    rollIdx <= rollIdx + IDX_W'(1);
                    if (rollIdx == IDX_W'(`REG_COUNT - 1)) begin
                        state <= RollIdle;
                    end
                end
                default: begin
                    state <= RollIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, everything ready
            for (int i = 0; i < `REG_COUNT; i++) begin
                specTag[i]   <= `TAG_WIDTH'(i);
                commitTag[i] <= `TAG_WIDTH'(i);
                avail[i]     <= 1'b1;
            end
        end else begin
            if (wbHit) begin
                avail[wbReg] <= 1'b1;
            end

            // Allocation after write-back so a fresh mapping starts pending
            if (allocHit) begin
                specTag[allocReg] <= allocTag;
                avail[allocReg]   <= 1'b0;
            end

            if (comHit) begin
                commitTag[comReg] <= comTag;
                // Entries the walk already passed follow the commit directly
                if (rolling && (comReg < rollIdx)) begin
                    specTag[comReg] <= comTag;
                    avail[comReg]   <= 1'b1;
                end
            end

            if (drop) begin
                specTag[rollIdx] <= stepTag;
                avail[rollIdx]   <= 1'b1;
            end
        end
    end

endmodule

// ==== design/renameStage.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module renameStage (
    input  logic                          clk,
    input  logic                          rst,

    // Decoded op
    input  logic                          en,
    input  renamePkg::OpCode              opcode,
    input  renamePkg::FuKind              fu,
    input  logic [$clog2(`REG_COUNT)-1:0] rs0,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1,
    input  logic [$clog2(`REG_COUNT)-1:0] rd,

    // Result write-back, speculative
    input  logic                          wbValid,
    input  logic [$clog2(`REG_COUNT)-1:0] wbReg,
    input  logic [`TAG_WIDTH-1:0]         wbTag,

    // In-order commit
    input  logic                          comValid,
    input  logic [$clog2(`REG_COUNT)-1:0] comReg,
    input  logic [`TAG_WIDTH-1:0]         comTag,

    // Mispredicted branch at commit
    input  logic                          flush,
    input  logic [`SQN_WIDTH-1:0]         flushSqN,

    output logic                          ready,
    output logic [`SQN_WIDTH-1:0]         nextSqN,

    // Renamed op
    output logic                          uopValid,
    output renamePkg::OpCode              uopOpcode,
    output renamePkg::FuKind              uopFu,
    output logic [$clog2(`REG_COUNT)-1:0] uopRd,
    output logic [`SQN_WIDTH-1:0]         uopSqN,
    output logic [`TAG_WIDTH-1:0]         tagA,
    output logic                          availA,
    output logic [`TAG_WIDTH-1:0]         tagB,
    output logic                          availB,
    output logic [`TAG_WIDTH-1:0]         tagDst
);
    logic [`TAG_WIDTH-1:0] lookTagA;
    logic                  lookAvailA;
    logic [`TAG_WIDTH-1:0] lookTagB;
    logic                  lookAvailB;

    logic                  retire;
    logic [`TAG_WIDTH-1:0] retireTag;
    logic                  drop;
    logic [`TAG_WIDTH-1:0] dropTag;
    logic                  rolling;

    logic [`TAG_WIDTH-1:0] headTag;
    logic                  empty;

    logic                  needTag;
    logic                  accept;
    logic                  alloc;
    logic [`SQN_WIDTH-1:0] sqN;

    // x0 needs no tag, so an empty list only stalls real destinations
    assign needTag = (rd != '0);
    assign ready   = !rolling && !(empty && needTag);
    assign accept  = en && ready && !flush;
    assign alloc   = accept && needTag;

    assign nextSqN = sqN;

    aliasTable aliasTable_i (
        .clk       (clk),
        .rst       (rst),
        .rs0       (rs0),
        .rs1       (rs1),
        .alloc     (alloc),
        .allocReg  (rd),
        .allocTag  (headTag),
        .wbValid   (wbValid),
        .wbReg     (wbReg),
        .wbTag     (wbTag),
        .comValid  (comValid),
        .comReg    (comReg),
        .comTag    (comTag),
        .flush     (flush),
        .tagA      (lookTagA),
        .availA    (lookAvailA),
        .tagB      (lookTagB),
        .availB    (lookAvailB),
        .retire    (retire),
        .retireTag (retireTag),
        .drop      (drop),
        .dropTag   (dropTag),
        .rolling   (rolling)
    );

    // Retired tags on port A, rolled-back tags on port B
    freeTagList freeTagList_i (
        .clk     (clk),
        .rst     (rst),
        .pop     (alloc),
        .pushA   (retire),
        .tagA    (retireTag),
        .pushB   (drop),
        .tagB    (dropTag),
        .headTag (headTag),
        .empty   (empty)
    );

    // Sequence counter restarts right after the flushing branch
    always_ff @(posedge clk) begin
        if (rst) begin
            sqN <= '0;
        end else if (flush) begin
            sqN <= flushSqN + `SQN_WIDTH'(1);
        end else if (accept) begin
            sqN <= sqN + `SQN_WIDTH'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uopValid <= 1'b0;
        end else begin
            uopValid <= accept;
        end
    end

    // Output op, only loaded on issue
    always_ff @(posedge clk) begin
        if (accept) begin
            uopOpcode <= opcode;
            uopFu     <= fu;
            uopRd     <= rd;
            uopSqN    <= sqN;
            tagA      <= lookTagA;
            availA    <= lookAvailA;
            tagB      <= lookTagB;
            availB    <= lookAvailB;
            tagDst    <= needTag ? headTag : '0;
        end
    end

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter realtime PERIOD = 100ns
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== dv/rename_props.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          flush,
    input logic                          ready,
    input logic [`SQN_WIDTH-1:0]         nextSqN,
    input logic                          uopValid,
    input renamePkg::OpCode              uopOpcode,
    input renamePkg::FuKind              uopFu,
    input logic [$clog2(`REG_COUNT)-1:0] uopRd,
    input logic [`SQN_WIDTH-1:0]         uopSqN,
    input logic [`TAG_WIDTH-1:0]         tagA,
    input logic                          availA,
    input logic [`TAG_WIDTH-1:0]         tagB,
    input logic                          availB,
    input logic [`TAG_WIDTH-1:0]         tagDst
);
    import renamePkg::*;

    int                    failCount = 0;

    logic                  lastValid = 1'b0;
    OpCode                 lastOpcode;
    FuKind                 lastFu;
    logic [$clog2(`REG_COUNT)-1:0] lastRd;
    logic [`SQN_WIDTH-1:0] lastSqN;
    logic [`TAG_WIDTH-1:0] lastTagA;
    logic                  lastAvailA;
    logic [`TAG_WIDTH-1:0] lastTagB;
    logic                  lastAvailB;
    logic [`TAG_WIDTH-1:0] lastTagDst;

    // Model expectation for the op accepted at the previous edge
    always_ff @(posedge clk) begin
        lastValid  <= renameTb.expValid;
        lastOpcode <= renameTb.expOpcode;
        lastFu     <= renameTb.expFu;
        lastRd     <= renameTb.expRd;
        lastSqN    <= renameTb.expSqN;
        lastTagA   <= renameTb.expTagA;
        lastAvailA <= renameTb.expAvailA;
        lastTagB   <= renameTb.expTagB;
        lastAvailB <= renameTb.expAvailB;
        lastTagDst <= renameTb.expTagDst;
    end

    readyOk: assert property (@(posedge clk) disable iff (rst) ready == renameTb.expReady)
        else begin
            $error("Error ready dut %h model %h", ready, $sampled(renameTb.expReady));
            failCount++;
        end

    nextSqNOk: assert property (@(posedge clk) disable iff (rst) nextSqN == renameTb.expNext)
        else begin
            $error("Error nextSqN dut %h model %h", nextSqN, $sampled(renameTb.expNext));
            failCount++;
        end

    validOk: assert property (@(posedge clk) disable iff (rst) uopValid == lastValid)
        else begin
            $error("Error uopValid dut %h model %h", uopValid, $sampled(lastValid));
            failCount++;
        end

    flushKills: assert property (@(posedge clk) disable iff (rst) flush |=> !uopValid)
        else begin
            $error("Error uopValid dut %h model %h after flush", uopValid, 1'b0);
            failCount++;
        end

    // Payload checked only while an op is presented
    passOk: assert property (@(posedge clk) disable iff (rst)
            lastValid |-> (uopOpcode == lastOpcode) && (uopFu == lastFu) && (uopRd == lastRd))
        else begin
            $error("Error uopOpcode/uopFu/uopRd dut %h/%h/%h model %h/%h/%h",
                   uopOpcode, uopFu, uopRd,
                   $sampled(lastOpcode), $sampled(lastFu), $sampled(lastRd));
            failCount++;
        end

    sqnOk: assert property (@(posedge clk) disable iff (rst) lastValid |-> uopSqN == lastSqN)
        else begin
            $error("Error uopSqN dut %h model %h", uopSqN, $sampled(lastSqN));
            failCount++;
        end

    srcAOk: assert property (@(posedge clk) disable iff (rst)
            lastValid |-> (tagA == lastTagA) && (availA == lastAvailA))
        else begin
            $error("Error tagA/availA dut %h/%h model %h/%h", tagA, availA,
                   $sampled(lastTagA), $sampled(lastAvailA));
            failCount++;
        end

    srcBOk: assert property (@(posedge clk) disable iff (rst)
            lastValid |-> (tagB == lastTagB) && (availB == lastAvailB))
        else begin
            $error("Error tagB/availB dut %h/%h model %h/%h", tagB, availB,
                   $sampled(lastTagB), $sampled(lastAvailB));
            failCount++;
        end

    dstOk: assert property (@(posedge clk) disable iff (rst) lastValid |-> tagDst == lastTagDst)
        else begin
            $error("Error tagDst dut %h model %h", tagDst, $sampled(lastTagDst));
            failCount++;
        end

endmodule

// ==== dv/renameTb.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module renameTb;
    import renamePkg::*;

    localparam int REG_W       = $clog2(`REG_COUNT);
    localparam int STEPS       = 30;
    localparam int STEP_CYCLES = 40;

    logic                  clk;
    logic                  rst;
    logic                  en;
    OpCode                 opcode;
    FuKind                 fu;
    logic [REG_W-1:0]      rs0, rs1, rd;
    logic                  wbValid, comValid, flush;
    logic [REG_W-1:0]      wbReg, comReg;
    logic [`TAG_WIDTH-1:0] wbTag, comTag;
    logic [`SQN_WIDTH-1:0] flushSqN;
    logic                  ready, uopValid, availA, availB;
    logic [`SQN_WIDTH-1:0] nextSqN, uopSqN;
    OpCode                 uopOpcode;
    FuKind                 uopFu;
    logic [REG_W-1:0]      uopRd;
    logic [`TAG_WIDTH-1:0] tagA, tagB, tagDst;

    // Reference model of table, free list and sequence counter
    logic [`TAG_WIDTH-1:0] specM [`REG_COUNT];
    logic [`TAG_WIDTH-1:0] comM  [`REG_COUNT];
    logic                  availM[`REG_COUNT];
    logic [`TAG_WIDTH-1:0] freeQ[$];
    logic [REG_W-1:0]      flightReg[$];
    logic [`TAG_WIDTH-1:0] flightTag[$];
    logic [`SQN_WIDTH-1:0] sqnM;
    int                    rollLeft;
    logic [REG_W-1:0]      rollIdxM;
    logic [31:0]           seed = 32'h82f7;

    // Expected values for the coming edge, read by the bound properties
    logic                  expReady = 1'b1;
    logic                  expValid = 1'b0;
    OpCode                 expOpcode = OpAdd;
    FuKind                 expFu = FuInt;
    logic [REG_W-1:0]      expRd = '0;
    logic [`SQN_WIDTH-1:0] expNext = '0, expSqN = '0;
    logic [`TAG_WIDTH-1:0] expTagA = '0, expTagB = '0, expTagDst = '0;
    logic                  expAvailA = 1'b0, expAvailB = 1'b0;

    clockGen clockGen_i (.clk(clk));

    renameStage renameStage_i (.*);

    bind renameStage rename_props props_i (.*);

    function automatic int rnd(input int n);
        seed = seed * 32'd1103515245 + 32'd12345;
        return int'(seed[30:16]) % n;
    endfunction

    task automatic resetModel();
        for (int i = 0; i < `REG_COUNT; i++) begin
            specM[i]  = `TAG_WIDTH'(i);
            comM[i]   = `TAG_WIDTH'(i);
            availM[i] = 1'b1;
        end
        freeQ.delete();
        for (int i = 0; i < `FREE_COUNT; i++) begin
            freeQ.push_back(`TAG_WIDTH'(`REG_COUNT + i));
        end
        flightReg.delete();
        flightTag.delete();
        sqnM     = '0;
        rollLeft = 0;
        rollIdxM = '0;
    endtask

    // Predict this edge from the driven inputs, then advance the model past it
    task automatic predictEdge();
        logic                  rolling, accept, wbHit, comHit, drop;
        logic [REG_W-1:0]      idx;
        logic [`TAG_WIDTH-1:0] target;
        rolling   = rollLeft > 0;
        expReady  = !rolling && !(freeQ.size() == 0 && rd != 0);
        accept    = en && expReady && !flush;
        expValid  = accept;
        expOpcode = opcode;
        expFu     = fu;
        expRd     = rd;
        expNext   = sqnM;
        expSqN    = sqnM;
        expTagA   = (rs0 == 0) ? '0 : specM[rs0];
        expAvailA = (rs0 == 0) || availM[rs0];
        expTagB   = (rs1 == 0) ? '0 : specM[rs1];
        expAvailB = (rs1 == 0) || availM[rs1];
        expTagDst = (rd != 0 && freeQ.size() > 0) ? freeQ[0] : '0;

        wbHit  = wbValid && wbReg != 0 && !rolling && !flush && specM[wbReg] == wbTag;
        comHit = comValid && comReg != 0;
        idx    = rollIdxM;
        target = (comHit && comReg == idx) ? comTag : comM[idx];
        drop   = rolling && specM[idx] != target;

        if (wbHit) availM[wbReg] = 1'b1;
        if (accept && rd != 0) begin
            specM[rd]  = freeQ.pop_front();
            availM[rd] = 1'b0;
            flightReg.push_back(rd);
            flightTag.push_back(specM[rd]);
        end
        if (comHit) begin
            freeQ.push_back(comM[comReg]);
            comM[comReg] = comTag;
            if (rolling && comReg < idx) begin
                specM[comReg]  = comTag;
                availM[comReg] = 1'b1;
            end
        end
        if (drop) begin
            freeQ.push_back(specM[idx]);
            specM[idx]  = target;
            availM[idx] = 1'b1;
        end
        if (rolling) begin
            rollIdxM++;
            rollLeft--;
        end else if (flush) begin
            rollLeft = `REG_COUNT;
            rollIdxM = '0;
        end
        if (flush) begin
            sqnM = flushSqN + `SQN_WIDTH'(1);
            flightReg.delete();
            flightTag.delete();
        end else if (accept) begin
            sqnM++;
        end
    endtask

    task automatic runCycle();
        predictEdge();
        @(posedge clk);
        #1;
        en       = 1'b0;
        wbValid  = 1'b0;
        comValid = 1'b0;
        flush    = 1'b0;
    endtask

    task automatic setOp(input int a, input int b, input int d);
        en     = 1'b1;
        opcode = OpCode'(rnd(10));
        fu     = FuKind'(rnd(3));
        rs0    = REG_W'(a);
        rs1    = REG_W'(b);
        rd     = REG_W'(d);
    endtask

    task automatic issueOp(input int a, input int b, input int d);
        setOp(a, b, d);
        runCycle();
    endtask

    task automatic setCommit();
        if (flightReg.size() > 0) begin
            comValid = 1'b1;
            comReg   = flightReg.pop_front();
            comTag   = flightTag.pop_front();
        end
    endtask

    task automatic setWriteBack(input int reg_, input logic [`TAG_WIDTH-1:0] tag);
        wbValid = 1'b1;
        wbReg   = REG_W'(reg_);
        wbTag   = tag;
    endtask

    task automatic flushAndWait();
        int waited;
        // An op offered together with the flush is squashed
        setOp(rnd(32), rnd(32), 0);
        flush    = 1'b1;
        flushSqN = `SQN_WIDTH'(rnd(64));
        runCycle();
        waited = 0;
        // Ops offered during the walk must be held back
        setOp(rnd(32), rnd(32), 0);
        while (!ready) begin
            runCycle();
            setOp(rnd(32), rnd(32), 0);
            waited++;
            if (waited > 2 * `REG_COUNT) begin
                $display("Test FAILED");
                $fatal(1, "ready stayed low after rollback");
            end
        end
        runCycle();
        for (int i = 0; i < `REG_COUNT / 2; i++) begin
            issueOp(2 * i, 2 * i + 1, 0);
        end
    endtask

    task automatic randomTraffic(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            if (rnd(4) != 0) setOp(rnd(32), rnd(32), (rnd(8) == 0) ? 0 : 1 + rnd(31));
            else rd = '0;
            if (rnd(2) == 0 && flightReg.size() > 0) begin
                int k;
                k = rnd(flightReg.size());
                setWriteBack(flightReg[k], flightTag[k]);
            end
            if (rnd(3) == 0) setCommit();
            runCycle();
        end
    endtask

    // Watchdog
    initial begin
        repeat (STEPS * STEP_CYCLES) @(posedge clk);
        $display("Test FAILED");
        $fatal(1, "simulation ran past its cycle budget");
    end

    always @(posedge clk) begin
        if (renameStage_i.props_i.failCount != 0) begin
            $display("Test FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        logic [`TAG_WIDTH-1:0] staleTag;
        rst = 1'b1;
        en = 1'b0;
        opcode = OpAdd;
        fu = FuInt;
        rs0 = '0;
        rs1 = '0;
        rd = '0;
        wbValid = 1'b0;
        wbReg = '0;
        wbTag = '0;
        comValid = 1'b0;
        comReg = '0;
        comTag = '0;
        flush = 1'b0;
        flushSqN = '0;
        resetModel();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Identity mapping and sequence numbers from zero
        for (int i = 0; i < 8; i++) issueOp(rnd(32), rnd(32), 0);

        // Allocation, then a stale and a matching write-back
        issueOp(1, 2, 5);
        staleTag = specM[5];
        issueOp(5, 0, 5);
        issueOp(5, 5, 0);
        setWriteBack(5, staleTag);
        runCycle();
        issueOp(5, 3, 0);
        setWriteBack(5, specM[5]);
        runCycle();
        issueOp(3, 5, 0);

        // Drain the free list, then stall on it
        while (freeQ.size() > 0) issueOp(rnd(32), rnd(32), 1 + rnd(31));
        for (int i = 0; i < 3; i++) issueOp(rnd(32), rnd(32), 1 + rnd(31));
        for (int i = 0; i < 4; i++) begin
            setCommit();
            runCycle();
        end
        for (int i = 0; i < 4; i++) issueOp(rnd(32), rnd(32), 1 + rnd(31));

        randomTraffic(300);
        flushAndWait();
        randomTraffic(100);
        flushAndWait();
        runCycle();
        runCycle();

        if (renameStage_i.props_i.failCount != 0) begin
            $display("Test FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+design
design/renamePkg.sv
design/freeTagList.sv
design/aliasTable.sv
design/renameStage.sv
dv/clockGen.sv
dv/rename_props.sv
dv/renameTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= renameTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@$(SIM) $(RUN_ARGS) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
